// ==== include/score_defs.svh ====
`ifndef SCORE_DEFS_SVH
`define SCORE_DEFS_SVH

`define COORD_W 10

// 640x480 at 60 Hz, 25 MHz pixel clock
`define H_ACTIVE 640
`define H_FRONT  16
`define H_SYNC   96
`define H_BACK   48
`define H_TOTAL  (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_ACTIVE 480
`define V_FRONT  10
`define V_SYNC   2
`define V_BACK   33
`define V_TOTAL  (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// score cells, lower right of the screen
`define SCORE_Y_TOP    466
`define SCORE_Y_BOTTOM 475
`define TENS_X_LEFT    445
`define UNITS_X_LEFT   460
`define GLYPH_SIZE     10

`define FG_RGB 12'hFFF
`define BG_RGB 12'h024

`endif

// ==== logic/score_pkg.sv ====
package score_pkg;

   // where the raster sits relative to the score band
   typedef enum logic [1:0] {
      region_outside,   // not on a glyph row, or on one but away from the cells
      region_gap,       // between the tens and units cells
      region_tens,
      region_units
   } score_region_t;

   // one decimal digit, 0 to 9
   typedef logic [3:0] bcd_digit_t;

endpackage

// ==== logic/vga_timing.sv ====
`timescale 1ns/1ns
`include "score_defs.svh"

module vga_timing (
   input  logic                clock_25,
   input  logic                reset,
   output logic [`COORD_W-1:0] x,
   output logic [`COORD_W-1:0] y,
   output logic                hsync_raw,
   output logic                vsync_raw,
   output logic                active
);

   logic [`COORD_W-1:0] x_next;
   logic [`COORD_W-1:0] y_next;
   logic                hsync_next;
   logic                vsync_next;
   logic                active_next;

   always_comb begin
      x_next = x + 1'b1;
      y_next = y;
      if (x == `H_TOTAL - 1) begin
         x_next = '0;
         if (y == `V_TOTAL - 1)
            y_next = '0;   // end of frame
         else
            y_next = y + 1'b1;
      end
   end

   // syncs and active follow the next counter values, so they line up with x and y
   always_comb begin
      hsync_next = 1'b1;
      vsync_next = 1'b1;
      if (x_next >= `H_ACTIVE + `H_FRONT && x_next < `H_ACTIVE + `H_FRONT + `H_SYNC)
         hsync_next = 1'b0;
      if (y_next >= `V_ACTIVE + `V_FRONT && y_next < `V_ACTIVE + `V_FRONT + `V_SYNC)
         vsync_next = 1'b0;
      active_next = (x_next < `H_ACTIVE) && (y_next < `V_ACTIVE);
   end

   always_ff @(posedge clock_25 or negedge reset) begin
      if (!reset) begin
         x         <= '0;
         y         <= '0;
         hsync_raw <= 1'b1;
         vsync_raw <= 1'b1;
         active    <= 1'b1;   // pixel 0,0 is visible
      end else begin
         x         <= x_next;
         y         <= y_next;
         hsync_raw <= hsync_next;
         vsync_raw <= vsync_next;
         active    <= active_next;
      end
   end

endmodule

// ==== logic/score_bcd_counter.sv ====
`timescale 1ns/1ns

module score_bcd_counter
   import score_pkg::*;
(
   input  logic       clock_25,
   input  logic       reset,
   input  logic       sync_reset,
   input  logic [6:0] score,
   output bcd_digit_t tens,
   output bcd_digit_t units
);

   logic [6:0] score_prev;   // highest score seen so far

   // one count per rise of the score, whatever the step size
   always_ff @(posedge clock_25 or negedge reset) begin
      if (!reset) begin
         tens       <= '0;
         units      <= '0;
         score_prev <= '0;
      end else if (sync_reset) begin
         tens       <= '0;
         units      <= '0;
         score_prev <= '0;
      end else if (score > score_prev) begin
         score_prev <= score;
         if (units == 4'd9) begin
            units <= '0;
            if (tens == 4'd9)
               tens <= '0;   // 99 wraps to 00
            else
               tens <= tens + 1'b1;
         end else begin
            units <= units + 1'b1;
         end
      end
   end

endmodule

// ==== logic/score_controller.sv ====
`timescale 1ns/1ns
`include "score_defs.svh"

module score_controller
   import score_pkg::*;
(
   input  logic                clock_25,
   input  logic                reset,
   input  logic                sync_reset,
   input  logic [`COORD_W-1:0] x,
   input  logic [`COORD_W-1:0] y,
   input  bcd_digit_t          tens,
   input  bcd_digit_t          units,
   output bcd_digit_t          digit_sel,
   output logic [6:0]          glyph_addr,
   output logic                glyph_en
);

   score_region_t       region;
   logic                in_rows;
   logic [3:0]          cell_col;
   logic [3:0]          glyph_row;
   logic [`COORD_W-1:0] y_prev;     // last glyph row the tracker counted
   logic [6:0]          row_base;

   assign in_rows = (y >= `SCORE_Y_TOP) && (y <= `SCORE_Y_BOTTOM);

   // 8*row + 2*row
   assign row_base = {glyph_row, 3'b000} + {2'b00, glyph_row, 1'b0};

   always_comb begin
      region   = region_outside;
      cell_col = '0;
      if (in_rows) begin
         if (x >= `TENS_X_LEFT && x < `TENS_X_LEFT + `GLYPH_SIZE) begin
            region   = region_tens;
            cell_col = 4'(x - `TENS_X_LEFT);
         end else if (x >= `TENS_X_LEFT + `GLYPH_SIZE && x < `UNITS_X_LEFT) begin
            region = region_gap;
         end else if (x >= `UNITS_X_LEFT && x < `UNITS_X_LEFT + `GLYPH_SIZE) begin
            region   = region_units;
            cell_col = 4'(x - `UNITS_X_LEFT);
         end
      end
   end

   // row counter steps at the start of each new line long before the cells at x=445
   always_ff @(posedge clock_25 or negedge reset) begin
      if (!reset) begin
         glyph_row <= '0;
         y_prev    <= `SCORE_Y_TOP;
      end else if (sync_reset || !in_rows) begin
         glyph_row <= '0;
         y_prev    <= `SCORE_Y_TOP;
      end else if (y > y_prev) begin
         glyph_row <= glyph_row + 1'b1;
         y_prev    <= y;
      end
   end

   always_ff @(posedge clock_25 or negedge reset) begin
      if (!reset) begin
         digit_sel  <= '0;
         glyph_addr <= '0;
         glyph_en   <= 1'b0;
      end else if (sync_reset) begin
         digit_sel  <= '0;
         glyph_addr <= '0;
         glyph_en   <= 1'b0;
      end else begin
         case (region)
            region_tens: begin
               digit_sel  <= tens;
               glyph_addr <= row_base + {3'b000, cell_col};
               glyph_en   <= 1'b1;
            end
            region_units: begin
               digit_sel  <= units;
               glyph_addr <= row_base + {3'b000, cell_col};
               glyph_en   <= 1'b1;
            end
            region_gap, region_outside: begin   // background pixel
               digit_sel  <= '0;
               glyph_addr <= '0;
               glyph_en   <= 1'b0;
            end
         endcase
      end
   end

endmodule

// ==== logic/digit_glyph_gen.sv ====
`timescale 1ns/1ns
`include "score_defs.svh"

module digit_glyph_gen
   import score_pkg::*;
(
   input  logic       clock_25,
   input  logic       reset,
   input  bcd_digit_t digit_sel,
   input  logic [6:0] glyph_addr,
   input  logic       glyph_en,
   output logic       glyph_bit
);

   logic [3:0] glyph_row;
   logic [3:0] glyph_col;
   logic       upper_half;
   logic       lower_half;
   logic [6:0] seg_hit;   // a..g, which segment this point falls on
   logic [6:0] seg_lit;   // a..g, which segments the digit lights

   assign glyph_row  = 4'(glyph_addr / `GLYPH_SIZE);
   assign glyph_col  = 4'(glyph_addr % `GLYPH_SIZE);
   assign upper_half = glyph_row < `GLYPH_SIZE / 2;
   assign lower_half = !upper_half;

   assign seg_hit[6] = glyph_row == 0;                                // a, top
   assign seg_hit[5] = (glyph_col == `GLYPH_SIZE - 1) && upper_half;  // b
   assign seg_hit[4] = (glyph_col == `GLYPH_SIZE - 1) && lower_half;  // c
   assign seg_hit[3] = glyph_row == `GLYPH_SIZE - 1;                  // d, bottom
   assign seg_hit[2] = (glyph_col == 0) && lower_half;                // e
   assign seg_hit[1] = (glyph_col == 0) && upper_half;                // f
   assign seg_hit[0] = (glyph_row == `GLYPH_SIZE / 2 - 1) ||
                       (glyph_row == `GLYPH_SIZE / 2);                // g, two rows thick

   always_comb begin
      case (digit_sel)
         4'd0:    seg_lit = 7'b1111110;
         4'd1:    seg_lit = 7'b0110000;
         4'd2:    seg_lit = 7'b1101101;
         4'd3:    seg_lit = 7'b1111001;
         4'd4:    seg_lit = 7'b0110011;
         4'd5:    seg_lit = 7'b1011011;
         4'd6:    seg_lit = 7'b1011111;
         4'd7:    seg_lit = 7'b1110000;
         4'd8:    seg_lit = 7'b1111111;
         4'd9:    seg_lit = 7'b1111011;
         default: seg_lit = 7'b0000000;   // not a decimal digit
      endcase
   end

   always_ff @(posedge clock_25 or negedge reset) begin
      if (!reset)
         glyph_bit <= 1'b0;
      else
         glyph_bit <= glyph_en && |(seg_hit & seg_lit);
   end

endmodule

// ==== logic/pixel_mixer.sv ====
`timescale 1ns/1ns
`include "score_defs.svh"

module pixel_mixer (
   input  logic        clock_25,
   input  logic        reset,
   input  logic        glyph_bit,
   input  logic        hsync_raw,
   input  logic        vsync_raw,
   input  logic        active,
   output logic [11:0] rgb,
   output logic        hsync,
   output logic        vsync
);

   // two delay stages here, the output register is the third
   logic [1:0] hsync_dly;
   logic [1:0] vsync_dly;
   logic [1:0] active_dly;

   always_ff @(posedge clock_25 or negedge reset) begin
      if (!reset) begin
         hsync_dly  <= 2'b11;
         vsync_dly  <= 2'b11;
         active_dly <= 2'b00;
         hsync      <= 1'b1;
         vsync      <= 1'b1;
         rgb        <= '0;
      end else begin
         hsync_dly  <= {hsync_dly[0], hsync_raw};
         vsync_dly  <= {vsync_dly[0], vsync_raw};
         active_dly <= {active_dly[0], active};
         hsync      <= hsync_dly[1];
         vsync      <= vsync_dly[1];
         if (!active_dly[1])
            rgb <= '0;   // blanking
         else if (glyph_bit)
            rgb <= `FG_RGB;
         else
            rgb <= `BG_RGB;
      end
   end

endmodule

// ==== logic/score_display_top.sv ====
`timescale 1ns/1ns
`include "score_defs.svh"

module score_display_top
   import score_pkg::*;
(
   input  logic        clock_25,
   input  logic        reset,
   input  logic        sync_reset,
   input  logic [6:0]  score,
   output logic        hsync,
   output logic        vsync,
   output logic [11:0] rgb
);

   logic [`COORD_W-1:0] x;
   logic [`COORD_W-1:0] y;
   logic                hsync_raw;
   logic                vsync_raw;
   logic                active;
   bcd_digit_t          tens;
   bcd_digit_t          units;
   bcd_digit_t          digit_sel;
   logic [6:0]          glyph_addr;
   logic                glyph_en;
   logic                glyph_bit;

   vga_timing u_timing (
      .clock_25  (clock_25),
      .reset     (reset),
      .x         (x),
      .y         (y),
      .hsync_raw (hsync_raw),
      .vsync_raw (vsync_raw),
      .active    (active)
   );

   score_bcd_counter u_counter (
      .clock_25   (clock_25),
      .reset      (reset),
      .sync_reset (sync_reset),
      .score      (score),
      .tens       (tens),
      .units      (units)
   );

   score_controller u_controller (
      .clock_25   (clock_25),
      .reset      (reset),
      .sync_reset (sync_reset),
      .x          (x),
      .y          (y),
      .tens       (tens),
      .units      (units),
      .digit_sel  (digit_sel),
      .glyph_addr (glyph_addr),
      .glyph_en   (glyph_en)
   );

   digit_glyph_gen u_glyph (
      .clock_25   (clock_25),
      .reset      (reset),
      .digit_sel  (digit_sel),
      .glyph_addr (glyph_addr),
      .glyph_en   (glyph_en),
      .glyph_bit  (glyph_bit)
   );

   pixel_mixer u_mixer (
      .clock_25  (clock_25),
      .reset     (reset),
      .glyph_bit (glyph_bit),
      .hsync_raw (hsync_raw),
      .vsync_raw (vsync_raw),
      .active    (active),
      .rgb       (rgb),
      .hsync     (hsync),
      .vsync     (vsync)
   );

endmodule

// ==== verification/score_display_tb.sv ====
`timescale 1ns/1ns
`include "score_defs.svh"

module score_display_tb;

   localparam int frame_cycles   = `H_TOTAL * `V_TOTAL;
   localparam int run_frames     = 8;   // tests 2 to 6 take about eight frames together
   localparam int timeout_cycles = (run_frames + 1) * frame_cycles;

   logic        clock_25;
   logic        reset;
   logic        sync_reset;
   logic [6:0]  score;
   logic        hsync;
   logic        vsync;
   logic [11:0] rgb;

   int          rx;               // model raster that follows the DUT counters
   int          ry;
   int          pipe_x [3];       // pixel held in each stage with [2] on the outputs
   int          pipe_y [3];
   logic        pipe_valid [3];
   int          exp_count;        // expected two-digit score
   int          exp_prev;         // highest score driven since the last clear
   int          shown_count;      // count latched as the frame starts
   logic [11:0] exp_rgb;
   logic        exp_hsync;
   logic        exp_vsync;
   int          hsync_low;
   int          vsync_low;
   int          errors;
   int          errors_at_start;
   int          tests_passed;
   int          tests_failed;
   int          cycle_count;

   score_display_top dut (
      .clock_25   (clock_25),
      .reset      (reset),
      .sync_reset (sync_reset),
      .score      (score),
      .hsync      (hsync),
      .vsync      (vsync),
      .rgb        (rgb)
   );

   initial begin
      clock_25 = 1'b0;
      forever #10 clock_25 = ~clock_25;
   end

   // pattern bits are g f e d c b a
   function automatic logic segment_lit(input int digit, input int row, input int col);
      logic [6:0] pattern;
      logic       upper;
      case (digit)
         0: pattern = 7'h3f;
         1: pattern = 7'h06;
         2: pattern = 7'h5b;
         3: pattern = 7'h4f;
         4: pattern = 7'h66;
         5: pattern = 7'h6d;
         6: pattern = 7'h7d;
         7: pattern = 7'h07;
         8: pattern = 7'h7f;
         default: pattern = 7'h6f;
      endcase
      upper = row < 5;
      return (pattern[0] && row == 0) || (pattern[1] && col == 9 && upper) ||
             (pattern[2] && col == 9 && !upper) || (pattern[3] && row == 9) ||
             (pattern[4] && col == 0 && !upper) || (pattern[5] && col == 0 && upper) ||
             (pattern[6] && (row == 4 || row == 5));
   endfunction

   function automatic logic [11:0] pixel_colour(input int px, input int py, input int count);
      int row;
      int col;
      int digit;
      row   = py - `SCORE_Y_TOP;
      col   = 0;
      digit = -1;
      if (px >= `H_ACTIVE || py >= `V_ACTIVE)
         return 12'h000;
      if (py >= `SCORE_Y_TOP && py <= `SCORE_Y_BOTTOM) begin
         if (px >= `TENS_X_LEFT && px < `TENS_X_LEFT + `GLYPH_SIZE) begin
            digit = count / 10;
            col   = px - `TENS_X_LEFT;
         end else if (px >= `UNITS_X_LEFT && px < `UNITS_X_LEFT + `GLYPH_SIZE) begin
            digit = count % 10;
            col   = px - `UNITS_X_LEFT;
         end
      end
      if (digit >= 0 && segment_lit(digit, row, col))
         return `FG_RGB;
      return `BG_RGB;
   endfunction

   always @(posedge clock_25 or negedge reset) begin
      if (!reset) begin
         rx          <= 0;
         ry          <= 0;
         shown_count <= 0;
         for (int i = 0; i < 3; i++) begin
            pipe_x[i]     <= 0;
            pipe_y[i]     <= 0;
            pipe_valid[i] <= 1'b0;
         end
      end else begin
         pipe_x[0]     <= rx;
         pipe_y[0]     <= ry;
         pipe_valid[0] <= 1'b1;
         for (int i = 1; i < 3; i++) begin
            pipe_x[i]     <= pipe_x[i-1];
            pipe_y[i]     <= pipe_y[i-1];
            pipe_valid[i] <= pipe_valid[i-1];
         end
         if (rx == `H_TOTAL - 1) begin
            rx <= 0;
            ry <= (ry == `V_TOTAL - 1) ? 0 : ry + 1;
         end else begin
            rx <= rx + 1;
         end
         if (rx == 0 && ry == 0)
            shown_count <= exp_count;   // digits only change in vertical blanking
      end
   end

   always_comb begin
      exp_rgb   = 12'h000;
      exp_hsync = 1'b1;
      exp_vsync = 1'b1;
      if (pipe_valid[2]) begin
         exp_rgb   = pixel_colour(pipe_x[2], pipe_y[2], shown_count);
         exp_hsync = !(pipe_x[2] >= `H_ACTIVE + `H_FRONT &&
                       pipe_x[2] < `H_ACTIVE + `H_FRONT + `H_SYNC);
         exp_vsync = !(pipe_y[2] >= `V_ACTIVE + `V_FRONT &&
                       pipe_y[2] < `V_ACTIVE + `V_FRONT + `V_SYNC);
      end
   end

   rgb_check: assert property (@(negedge clock_25) rgb == exp_rgb)
      else begin
         errors++;
         $display("** Error rgb: got %h, expected %h at pixel %0d,%0d",
                  rgb, exp_rgb, pipe_x[2], pipe_y[2]);
      end

   hsync_check: assert property (@(negedge clock_25) hsync == exp_hsync)
      else begin
         errors++;
         $display("** Error hsync: got %h, expected %h", hsync, exp_hsync);
      end

   vsync_check: assert property (@(negedge clock_25) vsync == exp_vsync)
      else begin
         errors++;
         $display("** Error vsync: got %h, expected %h", vsync, exp_vsync);
      end

   // pulse widths per line and per frame as seen on the outputs
   always @(negedge clock_25) begin
      if (pipe_valid[2]) begin
         if (pipe_x[2] == 0)
            hsync_low = 0;
         if (pipe_x[2] == 0 && pipe_y[2] == 0)
            vsync_low = 0;
         if (!hsync)
            hsync_low++;
         if (!vsync)
            vsync_low++;
         if (pipe_x[2] == `H_TOTAL - 1) begin
            hsync_width: assert (hsync_low == `H_SYNC) else begin
               errors++;
               $display("** Error hsync low clocks: got %h, expected %h", hsync_low, `H_SYNC);
            end
         end
         if (pipe_x[2] == `H_TOTAL - 1 && pipe_y[2] == `V_TOTAL - 1) begin
            vsync_width: assert (vsync_low == `V_SYNC * `H_TOTAL) else begin
               errors++;
               $display("** Error vsync low clocks: got %h, expected %h",
                        vsync_low, `V_SYNC * `H_TOTAL);
            end
         end
      end
   end

   always @(posedge clock_25) begin
      cycle_count++;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   task automatic wait_raster(input int wx, input int wy);
      do begin
         @(posedge clock_25);
         #2;
      end while (!(rx == wx && ry == wy));
   endtask

   // a rise over the highest score so far adds one and wraps at 100
   task automatic apply_score(input int value);
      score = 7'(value);
      if (value > exp_prev) begin
         exp_prev  = value;
         exp_count = (exp_count + 1) % 100;
      end
   endtask

   task automatic pulse_sync_reset();
      sync_reset = 1'b1;
      score      = 7'd0;
      exp_count  = 0;
      exp_prev   = 0;
      @(posedge clock_25);
      #2;
      sync_reset = 1'b0;
   endtask

   task automatic close_test(input string name);
      if (errors == errors_at_start) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d check errors", name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   initial begin
      int rises;
      reset           = 1'b0;
      sync_reset      = 1'b0;
      score           = 7'd0;
      exp_count       = 0;
      exp_prev        = 0;
      errors          = 0;
      errors_at_start = 0;
      tests_passed    = 0;
      tests_failed    = 0;
      cycle_count     = 0;
      hsync_low       = 0;
      vsync_low       = 0;
      void'($urandom(32'h41df));

      repeat (8) @(posedge clock_25);
      #2;
      reset = 1'b1;
      repeat (4) @(posedge clock_25);
      #2;
      close_test("reset values");

      wait_raster(0, `V_ACTIVE);
      wait_raster(8, 0);   // first output frame fully through the pipeline
      close_test("sync timing");

      wait_raster(0, `V_ACTIVE);
      close_test("score zero frame");

      // two random rises, then a held score, then a lowered one
      for (int step = 0; step < 4; step++) begin
         case (step)
            0, 1:    apply_score(int'(score) + int'($urandom_range(3, 1)));
            2:       apply_score(int'(score));
            default: apply_score(int'(score) - 1);
         endcase
         wait_raster(0, `V_ACTIVE);
      end
      close_test("score steps");

      rises = 103 - exp_count;   // passes 99 and lands on 03
      for (int i = 0; i < rises; i++) begin
         apply_score(exp_prev + 1);
         @(posedge clock_25);
         #2;
      end
      wait_raster(0, `V_ACTIVE);
      close_test("count wrap");

      pulse_sync_reset();
      wait_raster(0, `V_ACTIVE);
      wait_raster(8, 0);
      close_test("sync reset");

      $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
               tests_passed, tests_failed, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+include
logic/score_pkg.sv
logic/vga_timing.sv
logic/score_bcd_counter.sv
logic/score_controller.sv
logic/digit_glyph_gen.sv
logic/pixel_mixer.sv
logic/score_display_top.sv
verification/score_display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the score display testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
   --top-module score_display_tb -o score_display_sim \
   && ./obj_dir/score_display_sim > sim.log 2>&1 \
   || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0
